/* include/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// width of data, results and store masks.
`define LSU_XLEN 64
`define LSU_ADDR_WIDTH 64

// accesses between these bounds, both included, never reach the data memory.
`define LSU_MMIO_LO 64'h0000_0000_3000_0000
`define LSU_MMIO_HI 64'h0000_0000_4070_0000

`define LSU_FIFO_DEPTH 4

// the memory is LSU_MEM_WORDS double words deep.
`define LSU_MEM_WORDS 256

// cycles from acceptance to the done pulse, at least one.
`define LSU_MEM_LATENCY 2

`endif

/* rtl/lsu_pkg.sv */
package lsu_pkg;

    // one-hot access size as it arrives from decode.
    typedef enum logic [3:0] {
        LS_BYTE   = 4'b0001,
        LS_HALF   = 4'b0010,
        LS_WORD   = 4'b0100,
        LS_DOUBLE = 4'b1000
    } ls_size_t;

    typedef enum logic [1:0] {
        TBUS_NONE  = 2'b00,
        TBUS_READ  = 2'b01,
        TBUS_WRITE = 2'b10
    } tbus_op_t;

    // pending means the request is presented but the buffer is full.
    typedef enum logic [1:0] {
        LS_IDLE        = 2'b00,
        LS_PENDING     = 2'b01,
        LS_OUTSTANDING = 2'b10
    } ls_state_t;

endpackage

/* rtl/load_extract.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module load_extract (
    input  logic [`LSU_XLEN-1:0] read_data,
    input  logic [2:0]           address_low,
    input  lsu_pkg::ls_size_t    ls_size,
    input  logic                 is_unsigned,
    input  logic                 enable,
    output logic [`LSU_XLEN-1:0] load_data
);
    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0] lane;
    logic                 sign_byte;
    logic                 sign_half;
    logic                 sign_word;

    // move the addressed bytes down to bit 0.
    assign lane = read_data >> {address_low, 3'b000};

    assign sign_byte = lane[7] & ~is_unsigned;
    assign sign_half = lane[15] & ~is_unsigned;
    assign sign_word = lane[31] & ~is_unsigned;

    always_comb begin
        load_data = '0;
        if (enable) begin
            case (ls_size)
                LS_BYTE: begin
                    load_data = {{(`LSU_XLEN - 8){sign_byte}}, lane[7:0]};
                end
                LS_HALF: begin
                    load_data = {{(`LSU_XLEN - 16){sign_half}}, lane[15:0]};
                end
                LS_WORD: begin
                    load_data = {{(`LSU_XLEN - 32){sign_word}}, lane[31:0]};
                end
                LS_DOUBLE: begin
                    load_data = read_data; // a double word is always aligned.
                end
                default: begin
                    load_data = '0;
                end
            endcase
        end
    end

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module mem_stage (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       instr_valid,
    input  logic                       is_load,
    input  logic                       is_store,
    input  logic                       is_unsigned,
    input  lsu_pkg::ls_size_t          ls_size,
    input  logic [`LSU_XLEN-1:0]       imm,
    input  logic [`LSU_XLEN-1:0]       src1,
    input  logic [`LSU_XLEN-1:0]       src2,
    input  logic [`LSU_XLEN-1:0]       pc,
    input  logic [31:0]                instr,
    output logic                       tbus_index_valid,
    input  logic                       tbus_index_ready,
    output logic [`LSU_ADDR_WIDTH-1:0] tbus_index,
    output logic [`LSU_XLEN-1:0]       tbus_write_data,
    output logic [`LSU_XLEN-1:0]       tbus_write_mask,
    output lsu_pkg::tbus_op_t          tbus_operation_type,
    input  logic [`LSU_XLEN-1:0]       tbus_read_data,
    input  logic                       tbus_operation_done,
    output logic                       instr_valid_out,
    output logic [`LSU_XLEN-1:0]       pc_out,
    output logic [31:0]                instr_out,
    output logic [`LSU_XLEN-1:0]       ls_address,
    output logic [`LSU_XLEN-1:0]       load_data,
    output logic                       mem_stall
);
    import lsu_pkg::*;

    ls_state_t            ls_state;
    logic                 ls_valid;
    logic                 mmio_hit;
    logic                 access_req;
    logic                 req_fire;
    logic                 access_done;
    logic [5:0]           lane_shift;
    logic [`LSU_XLEN-1:0] size_mask;

    assign instr_valid_out = instr_valid;
    assign pc_out          = pc;
    assign instr_out       = instr;

    assign ls_address = src1 + imm;
    assign ls_valid   = is_load | is_store;
    assign mmio_hit   = ls_valid & (ls_address >= `LSU_MMIO_LO) & (ls_address <= `LSU_MMIO_HI);
    assign access_req = instr_valid & ls_valid & ~mmio_hit;
    assign lane_shift = {ls_address[2:0], 3'b000};

    always_comb begin
        case (ls_size)
            LS_BYTE:   size_mask = `LSU_XLEN'(8'hff);
            LS_HALF:   size_mask = `LSU_XLEN'(16'hffff);
            LS_WORD:   size_mask = `LSU_XLEN'(32'hffff_ffff);
            default:   size_mask = '1;
        endcase
    end

    // the request is withdrawn once it has been handed to the buffer.
    always_comb begin
        tbus_index_valid    = 1'b0;
        tbus_index          = '0;
        tbus_write_data     = '0;
        tbus_write_mask     = '0;
        tbus_operation_type = TBUS_NONE;
        if (access_req && ls_state != LS_OUTSTANDING) begin
            tbus_index_valid = 1'b1;
            tbus_index       = ls_address[`LSU_ADDR_WIDTH-1:0];
            if (is_store) begin
                tbus_write_data     = src2 << lane_shift;
                tbus_write_mask     = size_mask << lane_shift;
                tbus_operation_type = TBUS_WRITE;
            end else begin
                tbus_operation_type = TBUS_READ;
            end
        end
    end

    assign req_fire    = tbus_index_valid & tbus_index_ready;
    assign access_done = (ls_state == LS_OUTSTANDING) & tbus_operation_done;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ls_state <= LS_IDLE;
        end else begin
            case (ls_state)
                LS_IDLE: begin
                    if (req_fire) begin
                        ls_state <= LS_OUTSTANDING;
                    end else if (tbus_index_valid) begin
                        ls_state <= LS_PENDING; // buffer is full.
                    end
                end
                LS_PENDING: begin
                    if (req_fire) begin
                        ls_state <= LS_OUTSTANDING;
                    end
                end
                LS_OUTSTANDING: begin
                    if (tbus_operation_done) begin
                        ls_state <= LS_IDLE;
                    end
                end
                default: begin
                    ls_state <= LS_IDLE;
                end
            endcase
        end
    end

    // the instruction inputs are still held in the done cycle, so they select the lane.
    load_extract u_load_extract (
        .read_data  (tbus_read_data),
        .address_low(ls_address[2:0]),
        .ls_size    (ls_size),
        .is_unsigned(is_unsigned),
        .enable     (access_done & is_load),
        .load_data  (load_data)
    );

    assign mem_stall = ((ls_state != LS_IDLE) | tbus_index_valid) & ~access_done;

    a_request_held: assert property (
        @(posedge clock) disable iff (!reset_n)
        tbus_index_valid && !tbus_index_ready |=> tbus_index_valid
            && $stable(tbus_index) && $stable(tbus_operation_type)
            && $stable(tbus_write_data) && $stable(tbus_write_mask)
    ) else $error("request changed while waiting for the buffer");

    // a completion with nothing outstanding means memory and stage disagree.
    a_no_done_in_idle: assert property (
        @(posedge clock) disable iff (!reset_n)
        !(tbus_operation_done && ls_state == LS_IDLE)
    ) else $error("operation done while idle");

endmodule

/* rtl/tbus_req_fifo.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module tbus_req_fifo #(
    parameter int DEPTH = `LSU_FIFO_DEPTH
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [`LSU_ADDR_WIDTH-1:0] in_index,
    input  logic [`LSU_XLEN-1:0]       in_write_data,
    input  logic [`LSU_XLEN-1:0]       in_write_mask,
    input  lsu_pkg::tbus_op_t          in_operation_type,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [`LSU_ADDR_WIDTH-1:0] out_index,
    output logic [`LSU_XLEN-1:0]       out_write_data,
    output logic [`LSU_XLEN-1:0]       out_write_mask,
    output lsu_pkg::tbus_op_t          out_operation_type
);
    import lsu_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`LSU_ADDR_WIDTH-1:0] index_q [DEPTH];
    logic [`LSU_XLEN-1:0]       data_q  [DEPTH];
    logic [`LSU_XLEN-1:0]       mask_q  [DEPTH];
    tbus_op_t                   op_q    [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;
    logic                       push;
    logic                       pop;

    // wraps explicitly so that depths other than powers of two work.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            index_q[wr_ptr] <= in_index;
            data_q[wr_ptr]  <= in_write_data;
            mask_q[wr_ptr]  <= in_write_mask;
            op_q[wr_ptr]    <= in_operation_type;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign out_index          = index_q[rd_ptr];
    assign out_write_data     = data_q[rd_ptr];
    assign out_write_mask     = mask_q[rd_ptr];
    assign out_operation_type = op_q[rd_ptr];

    // the pointers meet exactly when the queue is full or empty.
    a_no_push_when_full: assert property (
        @(posedge clock) disable iff (!reset_n)
        (count == CNT_W'(DEPTH)) |-> (wr_ptr == rd_ptr)
    ) else $error("request buffer overflowed");

    a_no_pop_when_empty: assert property (
        @(posedge clock) disable iff (!reset_n)
        (count == '0) |-> (wr_ptr == rd_ptr)
    ) else $error("request buffer underflowed");

endmodule

/* rtl/tbus_sram.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module tbus_sram (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       hold,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  logic [`LSU_ADDR_WIDTH-1:0] req_index,
    input  logic [`LSU_XLEN-1:0]       req_write_data,
    input  logic [`LSU_XLEN-1:0]       req_write_mask,
    input  lsu_pkg::tbus_op_t          req_operation_type,
    output logic [`LSU_XLEN-1:0]       read_data,
    output logic                       operation_done
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
    localparam int CNT_W = ($clog2(`LSU_MEM_LATENCY) > 0) ? $clog2(`LSU_MEM_LATENCY) : 1;

    logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];
    logic [`LSU_XLEN-1:0] read_q;
    logic [IDX_W-1:0]     word_index;
    logic                 accept;
    logic                 busy;
    logic [CNT_W-1:0]     delay_cnt;

    // bits 2:0 select a byte inside the double word.
    assign word_index = req_index[IDX_W+2:3];

    assign req_ready = ~busy & ~hold;
    assign accept    = req_valid & req_ready;

    always_ff @(posedge clock) begin
        if (accept && req_operation_type == TBUS_WRITE) begin
            mem[word_index] <= (mem[word_index] & ~req_write_mask)
                             | (req_write_data & req_write_mask);
        end
        if (accept && req_operation_type == TBUS_READ) begin
            read_q <= mem[word_index]; // held until the done pulse.
        end
    end

    // one access in flight; the counter runs down to the done cycle.
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy      <= 1'b0;
            delay_cnt <= '0;
        end else if (accept) begin
            busy      <= 1'b1;
            delay_cnt <= CNT_W'(`LSU_MEM_LATENCY - 1);
        end else if (busy) begin
            if (delay_cnt == '0) begin
                busy <= 1'b0;
            end else begin
                delay_cnt <= delay_cnt - 1'b1;
            end
        end
    end

    assign operation_done = busy & (delay_cnt == '0);
    assign read_data      = read_q;

    a_done_single_cycle: assert property (
        @(posedge clock) disable iff (!reset_n)
        operation_done |=> !operation_done
    ) else $error("operation done held longer than one cycle");

endmodule

/* rtl/mem_subsystem.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module mem_subsystem (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 hold,
    input  logic                 instr_valid,
    input  logic                 is_load,
    input  logic                 is_store,
    input  logic                 is_unsigned,
    input  lsu_pkg::ls_size_t    ls_size,
    input  logic [`LSU_XLEN-1:0] imm,
    input  logic [`LSU_XLEN-1:0] src1,
    input  logic [`LSU_XLEN-1:0] src2,
    input  logic [`LSU_XLEN-1:0] pc,
    input  logic [31:0]          instr,
    output logic                 instr_valid_out,
    output logic [`LSU_XLEN-1:0] pc_out,
    output logic [31:0]          instr_out,
    output logic [`LSU_XLEN-1:0] ls_address,
    output logic [`LSU_XLEN-1:0] load_data,
    output logic                 mem_stall
);
    import lsu_pkg::*;

    // stage to buffer.
    logic                       tbus_index_valid;
    logic                       tbus_index_ready;
    logic [`LSU_ADDR_WIDTH-1:0] tbus_index;
    logic [`LSU_XLEN-1:0]       tbus_write_data;
    logic [`LSU_XLEN-1:0]       tbus_write_mask;
    tbus_op_t                   tbus_operation_type;

    // buffer to memory, and the completion back to the stage.
    logic                       mem_req_valid;
    logic                       mem_req_ready;
    logic [`LSU_ADDR_WIDTH-1:0] mem_req_index;
    logic [`LSU_XLEN-1:0]       mem_req_write_data;
    logic [`LSU_XLEN-1:0]       mem_req_write_mask;
    tbus_op_t                   mem_req_operation_type;
    logic [`LSU_XLEN-1:0]       tbus_read_data;
    logic                       tbus_operation_done;

    mem_stage u_mem_stage (
        .clock              (clock),
        .reset_n            (reset_n),
        .instr_valid        (instr_valid),
        .is_load            (is_load),
        .is_store           (is_store),
        .is_unsigned        (is_unsigned),
        .ls_size            (ls_size),
        .imm                (imm),
        .src1               (src1),
        .src2               (src2),
        .pc                 (pc),
        .instr              (instr),
        .tbus_index_valid   (tbus_index_valid),
        .tbus_index_ready   (tbus_index_ready),
        .tbus_index         (tbus_index),
        .tbus_write_data    (tbus_write_data),
        .tbus_write_mask    (tbus_write_mask),
        .tbus_operation_type(tbus_operation_type),
        .tbus_read_data     (tbus_read_data),
        .tbus_operation_done(tbus_operation_done),
        .instr_valid_out    (instr_valid_out),
        .pc_out             (pc_out),
        .instr_out          (instr_out),
        .ls_address         (ls_address),
        .load_data          (load_data),
        .mem_stall          (mem_stall)
    );

    tbus_req_fifo #(
        .DEPTH(`LSU_FIFO_DEPTH)
    ) u_tbus_req_fifo (
        .clock             (clock),
        .reset_n           (reset_n),
        .in_valid          (tbus_index_valid),
        .in_ready          (tbus_index_ready),
        .in_index          (tbus_index),
        .in_write_data     (tbus_write_data),
        .in_write_mask     (tbus_write_mask),
        .in_operation_type (tbus_operation_type),
        .out_valid         (mem_req_valid),
        .out_ready         (mem_req_ready),
        .out_index         (mem_req_index),
        .out_write_data    (mem_req_write_data),
        .out_write_mask    (mem_req_write_mask),
        .out_operation_type(mem_req_operation_type)
    );

    tbus_sram u_tbus_sram (
        .clock             (clock),
        .reset_n           (reset_n),
        .hold              (hold),
        .req_valid         (mem_req_valid),
        .req_ready         (mem_req_ready),
        .req_index         (mem_req_index),
        .req_write_data    (mem_req_write_data),
        .req_write_mask    (mem_req_write_mask),
        .req_operation_type(mem_req_operation_type),
        .read_data         (tbus_read_data),
        .operation_done    (tbus_operation_done)
    );

endmodule

/* testbench/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module tb_mem_subsystem;
    import lsu_pkg::*;

    localparam int CLK_PERIOD        = 8;
    localparam int NUM_TESTS         = 6;
    localparam int TEST_BOUND_CYCLES = 2000;
    localparam int ACCESS_LIMIT      = 64;
    localparam int HOLD_CYCLES       = 8;
    localparam int MAX_CYCLES        = 1 + `LSU_MEM_LATENCY;
    localparam int WATCHDOG_NS       = (NUM_TESTS * TEST_BOUND_CYCLES + 20) * CLK_PERIOD;

    logic                 clock;
    logic                 reset_n;
    logic                 hold;
    logic                 instr_valid;
    logic                 is_load;
    logic                 is_store;
    logic                 is_unsigned;
    ls_size_t             ls_size;
    logic [`LSU_XLEN-1:0] imm;
    logic [`LSU_XLEN-1:0] src1;
    logic [`LSU_XLEN-1:0] src2;
    logic [`LSU_XLEN-1:0] pc;
    logic [31:0]          instr;
    logic                 instr_valid_out;
    logic [`LSU_XLEN-1:0] pc_out;
    logic [31:0]          instr_out;
    logic [`LSU_XLEN-1:0] ls_address;
    logic [`LSU_XLEN-1:0] load_data;
    logic                 mem_stall;

    logic [`LSU_XLEN-1:0] shadow [`LSU_MEM_WORDS]; // expected memory contents.
    logic [`LSU_XLEN-1:0] exp_address; // the address that src1 and imm were split from.
    logic [31:0]          lfsr_state = 32'h809a;
    int                   value_errors = 0;
    int                   timing_errors = 0;

    mem_subsystem u_dut (
        .clock          (clock),
        .reset_n        (reset_n),
        .hold           (hold),
        .instr_valid    (instr_valid),
        .is_load        (is_load),
        .is_store       (is_store),
        .is_unsigned    (is_unsigned),
        .ls_size        (ls_size),
        .imm            (imm),
        .src1           (src1),
        .src2           (src2),
        .pc             (pc),
        .instr          (instr),
        .instr_valid_out(instr_valid_out),
        .pc_out         (pc_out),
        .instr_out      (instr_out),
        .ls_address     (ls_address),
        .load_data      (load_data),
        .mem_stall      (mem_stall)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    // fibonacci lfsr with taps 32, 22, 2 and 1 that steps once per bit.
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic int size_bytes(input ls_size_t size);
        case (size)
            LS_BYTE: return 1;
            LS_HALF: return 2;
            LS_WORD: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic int word_of(input logic [63:0] addr);
        return int'((addr >> 3) % `LSU_MEM_WORDS);
    endfunction

    // gathers the bytes one by one from the shadow and extends the top one.
    function automatic logic [63:0] expected_load(input logic [63:0] addr, input ls_size_t size,
                                                  input logic uns);
        logic [63:0] word;
        logic [63:0] v;
        int          n;
        int          off;
        int          k;
        word = shadow[word_of(addr)];
        n    = size_bytes(size);
        off  = int'(addr[2:0]);
        v    = '0;
        for (k = 0; k < n; k++) begin
            v[8*k +: 8] = word[8*(off+k) +: 8];
        end
        if (!uns && n < 8 && v[8*n-1]) begin
            for (k = 8 * n; k < 64; k++) begin
                v[k] = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        value_errors++;
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic check_passthrough();
        if (instr_valid_out !== instr_valid)
            report_mismatch("instr_valid_out", 64'(instr_valid_out), 64'(instr_valid));
        if (pc_out !== pc)
            report_mismatch("pc_out", pc_out, pc);
        if (instr_out !== instr)
            report_mismatch("instr_out", 64'(instr_out), 64'(instr));
        if (ls_address !== exp_address)
            report_mismatch("ls_address", ls_address, exp_address);
    endtask

    // called at a falling edge; splits the address into a random base and offset.
    task automatic present(input logic load, input logic store, input logic uns,
                           input ls_size_t size, input logic [63:0] addr,
                           input logic [63:0] data);
        logic [63:0] r;
        r           = rand_bits(12);
        exp_address = addr;
        imm         = {{52{r[11]}}, r[11:0]};
        src1        = addr - imm;
        src2        = data;
        is_load     = load;
        is_store    = store;
        is_unsigned = uns;
        ls_size     = size;
        pc          = rand_bits(30) << 2;
        r           = rand_bits(32);
        instr       = r[31:0];
        instr_valid = 1'b1;
    endtask

    task automatic wait_done(output int cycles);
        logic finished;
        cycles   = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clock);
            cycles++;
            check_passthrough();
            if (!mem_stall) begin
                finished = 1'b1;
            end else if (cycles >= ACCESS_LIMIT) begin
                timing_errors++;
                $display("at %0t the access to %h did not finish within %0d cycles",
                         $time, ls_address, ACCESS_LIMIT);
                finished = 1'b1;
            end
        end
    endtask

    // a bubble with random fields; nothing may reach memory.
    task automatic drive_idle();
        logic [63:0] r;
        r           = rand_bits(32);
        instr_valid = 1'b0;
        is_load     = r[0];
        is_store    = 1'b0;
        instr       = r[31:0];
        exp_address = rand_bits(40);
        imm         = rand_bits(12);
        src1        = exp_address - imm;
        src2        = rand_bits(64);
        pc          = rand_bits(30) << 2;
        @(negedge clock);
        check_passthrough();
        if (mem_stall !== 1'b0)
            report_mismatch("mem_stall in a bubble", 64'(mem_stall), 64'(0));
    endtask

    task automatic store_mem(input logic [63:0] addr, input ls_size_t size,
                             input logic [63:0] data, output int cycles);
        int w;
        int off;
        int k;
        present(1'b0, 1'b1, 1'b0, size, addr, data);
        wait_done(cycles);
        drive_idle();
        w   = word_of(addr);
        off = int'(addr[2:0]);
        for (k = 0; k < size_bytes(size); k++) begin
            shadow[w][8*(off+k) +: 8] = data[8*k +: 8];
        end
    endtask

    task automatic load_mem(input logic [63:0] addr, input ls_size_t size, input logic uns,
                            output logic [63:0] result, output int cycles);
        present(1'b1, 1'b0, uns, size, addr, '0);
        wait_done(cycles);
        result = load_data; // only valid in the done cycle.
        drive_idle();
    endtask

    task automatic mmio_access(input logic load, input ls_size_t size,
                               input logic [63:0] addr, input logic [63:0] data);
        present(load, ~load, 1'b0, size, addr, data);
        @(negedge clock);
        check_passthrough();
        if (mem_stall !== 1'b0)
            report_mismatch("mem_stall for mmio", 64'(mem_stall), 64'(0));
        if (load_data !== '0)
            report_mismatch("mmio load_data", load_data, '0);
        drive_idle();
    endtask

    task automatic double_roundtrip();
        logic [63:0] data;
        logic [63:0] result;
        int          cycles;
        int          w;
        for (w = 0; w < 32; w++) begin
            data = rand_bits(64);
            store_mem(64'(w) << 3, LS_DOUBLE, data, cycles);
            if (cycles > MAX_CYCLES) begin
                timing_errors++;
                $display("at %0t a store took %0d cycles, more than %0d", $time, cycles,
                         MAX_CYCLES);
            end
            load_mem(64'(w) << 3, LS_DOUBLE, 1'b0, result, cycles);
            if (result !== data)
                report_mismatch("double load", result, data);
            if (cycles > MAX_CYCLES) begin
                timing_errors++;
                $display("at %0t a load took %0d cycles, more than %0d", $time, cycles,
                         MAX_CYCLES);
            end
        end
    endtask

    task automatic partial_stores();
        ls_size_t    sizes [3] = '{LS_BYTE, LS_HALF, LS_WORD};
        logic [63:0] result;
        int          cycles;
        int          w;
        int          s;
        int          off;
        for (w = 0; w < 4; w++) begin
            for (s = 0; s < 3; s++) begin
                for (off = 0; off < 8; off += size_bytes(sizes[s])) begin
                    store_mem((64'(w) << 3) + 64'(off), sizes[s], rand_bits(64), cycles);
                    load_mem(64'(w) << 3, LS_DOUBLE, 1'b0, result, cycles);
                    if (result !== shadow[w])
                        report_mismatch("word after partial store", result, shadow[w]);
                end
            end
        end
    endtask

    task automatic extended_loads();
        ls_size_t    sizes [3] = '{LS_BYTE, LS_HALF, LS_WORD};
        logic [63:0] addr;
        logic [63:0] result;
        int          cycles;
        int          w;
        int          s;
        int          off;
        int          u;
        for (w = 4; w < 8; w++) begin
            for (s = 0; s < 3; s++) begin
                for (off = 0; off < 8; off += size_bytes(sizes[s])) begin
                    for (u = 0; u < 2; u++) begin
                        addr = (64'(w) << 3) + 64'(off);
                        load_mem(addr, sizes[s], u[0], result, cycles);
                        if (result !== expected_load(addr, sizes[s], u[0]))
                            report_mismatch("partial load", result,
                                            expected_load(addr, sizes[s], u[0]));
                    end
                end
            end
        end
    endtask

    task automatic load_under_hold();
        logic [63:0] addr;
        int          cycles;
        int          i;
        addr = (64'(9) << 3) + 64'(4);
        hold = 1'b1;
        present(1'b1, 1'b0, 1'b0, LS_WORD, addr, '0);
        for (i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clock);
            check_passthrough();
            if (mem_stall !== 1'b1)
                report_mismatch("mem_stall under hold", 64'(mem_stall), 64'(1));
        end
        hold = 1'b0;
        wait_done(cycles);
        if (load_data !== expected_load(addr, LS_WORD, 1'b0))
            report_mismatch("load after hold", load_data, expected_load(addr, LS_WORD, 1'b0));
        drive_idle();
    endtask

    // the window addresses alias words 10 and 0 if they ever reached memory.
    task automatic mmio_bypass();
        logic [63:0] addrs [3];
        logic [63:0] result;
        int          cycles;
        int          i;
        addrs[0] = `LSU_MMIO_LO + 64'h50;
        addrs[1] = 64'h3800_0050;
        addrs[2] = `LSU_MMIO_HI;
        for (i = 0; i < 3; i++) begin
            mmio_access(1'b0, LS_DOUBLE, addrs[i], rand_bits(64));
            mmio_access(1'b1, LS_DOUBLE, addrs[i], '0);
            mmio_access(1'b1, LS_BYTE, addrs[i], '0);
        end
        load_mem(64'(10) << 3, LS_DOUBLE, 1'b0, result, cycles);
        if (result !== shadow[10])
            report_mismatch("word 10 after mmio stores", result, shadow[10]);
        load_mem('0, LS_DOUBLE, 1'b0, result, cycles);
        if (result !== shadow[0])
            report_mismatch("word 0 after mmio stores", result, shadow[0]);
    endtask

    task automatic idle_bubbles();
        repeat (16) drive_idle();
    endtask

    initial begin
        clock       = 1'b0;
        reset_n     = 1'b0;
        hold        = 1'b0;
        instr_valid = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_unsigned = 1'b0;
        ls_size     = LS_DOUBLE;
        imm         = '0;
        src1        = '0;
        src2        = '0;
        pc          = '0;
        instr       = '0;
        exp_address = '0;
        repeat (10) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        if (mem_stall !== 1'b0)
            report_mismatch("mem_stall after reset", 64'(mem_stall), 64'(0));
        double_roundtrip(); // also fills words 0 to 31 of the shadow.
        partial_stores();
        extended_loads();
        load_under_hold();
        mmio_bypass();
        idle_bubbles();
        $display("value errors: %0d, timing errors: %0d", value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+include
rtl/lsu_pkg.sv
rtl/load_extract.sv
rtl/mem_stage.sv
rtl/tbus_req_fifo.sv
rtl/tbus_sram.sv
rtl/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/lsu_pkg.sv
      - rtl/load_extract.sv
      - rtl/mem_stage.sv
      - rtl/tbus_req_fifo.sv
      - rtl/tbus_sram.sv
      - rtl/mem_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_mem_subsystem.sv
